// ==== dhcp_msg_pkg.sv ====
package dhcp_msg_pkg;

  //////////////////////////////////////////////////////////////////////
  // basic field types
  //////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [31:0] xid_t;

  //////////////////////////////////////////////////////////////////////
  // fixed header layout, byte offsets from start of payload
  //////////////////////////////////////////////////////////////////////

  localparam int hdr_len    = 240; // cookie included
  localparam int off_op     = 0;
  localparam int off_xid    = 4;
  localparam int off_flags  = 10;
  localparam int off_yiaddr = 16;
  localparam int off_siaddr = 20;
  localparam int off_chaddr = 28;
  localparam int off_cookie = 236;

  localparam logic [31:0] magic_cookie = 32'h63825363;

  localparam byte_t op_boot_request = 8'd1;
  localparam byte_t op_boot_reply   = 8'd2;

  // option codes
  localparam byte_t opt_pad          = 8'd0;
  localparam byte_t opt_subnet_mask  = 8'd1;
  localparam byte_t opt_router       = 8'd3;
  localparam byte_t opt_requested_ip = 8'd50;
  localparam byte_t opt_msg_type     = 8'd53;
  localparam byte_t opt_server_id    = 8'd54;
  localparam byte_t opt_client_id    = 8'd61;
  localparam byte_t opt_end          = 8'd255;

  // values carried in option 53
  localparam byte_t msg_discover = 8'd1;
  localparam byte_t msg_offer    = 8'd2;
  localparam byte_t msg_request  = 8'd3;
  localparam byte_t msg_ack      = 8'd5;

endpackage

// ==== dhcp_client_pkg.sv ====
package dhcp_client_pkg;

  typedef logic [47:0] mac_t;
  typedef logic [15:0] tx_len_t;

  typedef enum logic [0:0] {
    kind_discover,
    kind_request
  } msg_kind_t;

  // locally administered address
  localparam mac_t               client_mac = 48'h02_00_5e_10_20_30;
  localparam dhcp_msg_pkg::xid_t client_xid = 32'hdeadface;

  localparam int startup_ticks       = 16;
  localparam int reply_timeout_ticks = 2000;
  localparam int max_retries         = 3;

  // msg type 3 + requested ip 6 + client id 9 + end 1
  localparam tx_len_t len_discover = tx_len_t'(dhcp_msg_pkg::hdr_len + 19);
  // server id adds 6 more
  localparam tx_len_t len_request  = tx_len_t'(dhcp_msg_pkg::hdr_len + 25);

endpackage

// ==== dhcp_reply_parser.sv ====
`timescale 1ns/1ps

module dhcp_reply_parser (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                rx_sof,
  input  logic                rx_val,
  input  dhcp_msg_pkg::byte_t rx_dat,
  input  logic                rx_eof,
  output logic                reply_val,
  output dhcp_msg_pkg::byte_t reply_op,
  output dhcp_msg_pkg::xid_t  reply_xid,
  output dhcp_msg_pkg::ipv4_t reply_yiaddr,
  output dhcp_msg_pkg::ipv4_t reply_siaddr,
  output dhcp_msg_pkg::ipv4_t reply_router,
  output dhcp_msg_pkg::ipv4_t reply_mask,
  output dhcp_msg_pkg::byte_t reply_msg_type,
  output logic                reply_router_pres,
  output logic                reply_mask_pres
);

  typedef enum logic [1:0] {opt_idle, opt_kind, opt_len, opt_data} opt_field_t;

  opt_field_t          opt_field;
  logic [15:0]         byte_cnt;
  int                  pos;         // index of the byte on rx_dat
  dhcp_msg_pkg::ipv4_t last4;
  dhcp_msg_pkg::ipv4_t word;        // last4 with current byte appended
  dhcp_msg_pkg::byte_t cur_kind;
  dhcp_msg_pkg::byte_t opt_len_q;
  dhcp_msg_pkg::byte_t opt_cnt;
  logic                opt_last;
  logic                end_hit;

  // values of the frame in progress
  dhcp_msg_pkg::byte_t op_q;
  dhcp_msg_pkg::xid_t  xid_q;
  dhcp_msg_pkg::ipv4_t yiaddr_q;
  dhcp_msg_pkg::ipv4_t siaddr_q;
  dhcp_msg_pkg::ipv4_t router_q;
  dhcp_msg_pkg::ipv4_t mask_q;
  dhcp_msg_pkg::byte_t msg_type_q;
  logic                router_pres_q;
  logic                mask_pres_q;

  assign pos      = rx_sof ? 0 : int'(byte_cnt);
  assign word     = {last4[23:0], rx_dat};
  assign opt_last = rx_val && !rx_sof && opt_field == opt_data && opt_cnt == opt_len_q - 8'd1;
  assign end_hit  = rx_val && !rx_sof && opt_field == opt_kind &&
                    rx_dat == dhcp_msg_pkg::opt_end;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      opt_field         <= opt_idle;
      byte_cnt          <= '0;
      reply_val         <= 1'b0;
      router_pres_q     <= 1'b0;
      mask_pres_q       <= 1'b0;
      reply_router_pres <= 1'b0;
      reply_mask_pres   <= 1'b0;
    end else begin
      reply_val <= end_hit;
      if (end_hit) begin
        reply_router_pres <= router_pres_q;
        reply_mask_pres   <= mask_pres_q;
      end
      if (rx_val) begin
        byte_cnt <= 16'(pos + 1);
        if (rx_sof) begin
          opt_field     <= opt_idle;
          router_pres_q <= 1'b0;
          mask_pres_q   <= 1'b0;
        end else begin
          case (opt_field)
            opt_kind: begin
              if (rx_dat == dhcp_msg_pkg::opt_end) opt_field <= opt_idle;
              else if (rx_dat != dhcp_msg_pkg::opt_pad) opt_field <= opt_len;
            end
            opt_len:  opt_field <= (rx_dat == 8'd0) ? opt_kind : opt_data;
            opt_data: begin
              if (opt_last) begin
                opt_field <= opt_kind;
                if (cur_kind == dhcp_msg_pkg::opt_router) router_pres_q <= 1'b1;
                if (cur_kind == dhcp_msg_pkg::opt_subnet_mask) mask_pres_q <= 1'b1;
              end
            end
            default: begin // still in header, options only behind a good cookie
              if (pos == dhcp_msg_pkg::hdr_len - 1 && word == dhcp_msg_pkg::magic_cookie)
                opt_field <= opt_kind;
            end
          endcase
        end
        if (rx_eof) opt_field <= opt_idle;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_val) begin
      last4 <= word;
      if (opt_field == opt_kind) cur_kind <= rx_dat;
      if (opt_field == opt_len) begin
        opt_len_q <= rx_dat;
        opt_cnt   <= 8'd0;
      end
      if (opt_field == opt_data) opt_cnt <= opt_cnt + 8'd1;
      case (pos)
        dhcp_msg_pkg::off_op: begin
          op_q       <= rx_dat;
          msg_type_q <= '0;                 // no stale type from older frame
        end
        dhcp_msg_pkg::off_xid + 3:    xid_q    <= word;
        dhcp_msg_pkg::off_yiaddr + 3: yiaddr_q <= word;
        dhcp_msg_pkg::off_siaddr + 3: siaddr_q <= word;
        default: ;
      endcase
      if (opt_last) begin
        case (cur_kind)
          dhcp_msg_pkg::opt_msg_type:    msg_type_q <= rx_dat;
          dhcp_msg_pkg::opt_router:      router_q   <= word;
          dhcp_msg_pkg::opt_subnet_mask: mask_q     <= word;
          default: ;
        endcase
      end
    end
    if (end_hit) begin
      reply_op       <= op_q;
      reply_xid      <= xid_q;
      reply_yiaddr   <= yiaddr_q;
      reply_siaddr   <= siaddr_q;
      reply_router   <= router_q;
      reply_mask     <= mask_q;
      reply_msg_type <= msg_type_q;
    end
  end

endmodule

// ==== dhcp_client_fsm.sv ====
`timescale 1ns/1ps

module dhcp_client_fsm (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  dhcp_msg_pkg::ipv4_t        preferred_ipv4,
  input  logic                       reply_val,
  input  dhcp_msg_pkg::byte_t        reply_op,
  input  dhcp_msg_pkg::xid_t         reply_xid,
  input  dhcp_msg_pkg::ipv4_t        reply_yiaddr,
  input  dhcp_msg_pkg::ipv4_t        reply_siaddr,
  input  dhcp_msg_pkg::ipv4_t        reply_router,
  input  dhcp_msg_pkg::ipv4_t        reply_mask,
  input  dhcp_msg_pkg::byte_t        reply_msg_type,
  input  logic                       reply_router_pres,
  input  logic                       reply_mask_pres,
  input  logic                       msg_sent,
  output logic                       msg_start,
  output dhcp_client_pkg::msg_kind_t msg_kind,
  output dhcp_msg_pkg::ipv4_t        req_ip,
  output dhcp_msg_pkg::ipv4_t        server_ip,
  output logic                       ready,
  output logic                       error,
  output logic                       dhcp_success,
  output logic                       dhcp_timeout,
  output dhcp_msg_pkg::ipv4_t        assigned_ipv4,
  output dhcp_msg_pkg::ipv4_t        router_ipv4_addr,
  output logic                       router_ipv4_addr_val,
  output dhcp_msg_pkg::ipv4_t        subnet_mask,
  output logic                       subnet_mask_val
);

  typedef enum logic [2:0] {
    st_idle, st_discover, st_wait_offer, st_request, st_wait_ack
  } state_t;

  state_t              state;
  logic [15:0]         startup_cnt;
  logic [15:0]         timer;
  logic [$clog2(dhcp_client_pkg::max_retries + 1)-1:0] retry_cnt;
  logic                sent_q;      // own message fully out, timer armed
  dhcp_msg_pkg::byte_t want_type;
  logic                reply_take;
  logic                timed_out;

  assign want_type  = (state == st_wait_ack) ? dhcp_msg_pkg::msg_ack : dhcp_msg_pkg::msg_offer;
  assign reply_take = reply_val && sent_q && reply_op == dhcp_msg_pkg::op_boot_reply &&
                      reply_xid == dhcp_client_pkg::client_xid && reply_msg_type == want_type;
  assign timed_out  = sent_q && timer == 16'(dhcp_client_pkg::reply_timeout_ticks - 1);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state                <= st_idle;
      startup_cnt          <= '0;
      timer                <= '0;
      retry_cnt            <= '0;
      sent_q               <= 1'b0;
      msg_start            <= 1'b0;
      ready                <= 1'b0;
      error                <= 1'b0;
      dhcp_success         <= 1'b0;
      dhcp_timeout         <= 1'b0;
      router_ipv4_addr_val <= 1'b0;
      subnet_mask_val      <= 1'b0;
    end else begin
      msg_start <= 1'b0;
      if (msg_sent) begin
        sent_q <= 1'b1;
        timer  <= '0;
      end else if (sent_q) begin
        timer <= timer + 16'd1;
      end
      case (state)
        st_idle: begin
          if (!ready && !error) begin
            if (startup_cnt == 16'(dhcp_client_pkg::startup_ticks - 1)) begin
              startup_cnt <= '0;
              state       <= st_discover;
            end else begin
              startup_cnt <= startup_cnt + 16'd1;
            end
          end
        end
        st_discover, st_request: begin
          msg_start <= 1'b1;
          sent_q    <= 1'b0;
          state     <= (state == st_discover) ? st_wait_offer : st_wait_ack;
        end
        st_wait_offer: if (reply_take) state <= st_request;
        st_wait_ack: begin
          if (reply_take) begin
            sent_q               <= 1'b0;
            ready                <= 1'b1;
            dhcp_success         <= 1'b1;
            router_ipv4_addr_val <= reply_router_pres;
            subnet_mask_val      <= reply_mask_pres;
            state                <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
      // attempt failed, back to startup delay
      if (timed_out && !reply_take) begin
        sent_q    <= 1'b0;
        state     <= st_idle;
        retry_cnt <= retry_cnt + 1'b1;
        if (int'(retry_cnt) == dhcp_client_pkg::max_retries - 1) begin
          error        <= 1'b1;
          dhcp_timeout <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_discover) begin
      msg_kind  <= dhcp_client_pkg::kind_discover;
      req_ip    <= preferred_ipv4;
      server_ip <= '0;
    end
    if (state == st_request) msg_kind <= dhcp_client_pkg::kind_request;
    if (state == st_wait_offer && reply_take) begin
      req_ip    <= reply_yiaddr; // offered address
      server_ip <= reply_siaddr;
    end
    if (state == st_wait_ack && reply_take) begin
      assigned_ipv4 <= reply_yiaddr;
      if (reply_router_pres) router_ipv4_addr <= reply_router;
      if (reply_mask_pres) subnet_mask <= reply_mask;
    end
  end

endmodule

// ==== dhcp_msg_serializer.sv ====
`timescale 1ns/1ps

module dhcp_msg_serializer (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       msg_start,
  input  dhcp_client_pkg::msg_kind_t msg_kind,
  input  dhcp_msg_pkg::ipv4_t        req_ip,
  input  dhcp_msg_pkg::ipv4_t        server_ip,
  input  logic                       tx_req,
  output logic                       tx_rdy,
  output dhcp_client_pkg::tx_len_t   tx_len,
  output logic                       tx_val,
  output logic                       tx_sof,
  output logic                       tx_eof,
  output dhcp_msg_pkg::byte_t        tx_dat,
  output logic                       msg_sent
);

  dhcp_client_pkg::tx_len_t idx;   // next byte to hand out
  logic                     fire;

  //////////////////////////////////////////////////////////////////////
  // payload byte at index i
  //////////////////////////////////////////////////////////////////////

  function automatic dhcp_msg_pkg::byte_t msg_byte(
    input int                  i,
    input logic                is_req,
    input dhcp_msg_pkg::ipv4_t rip,
    input dhcp_msg_pkg::ipv4_t sip
  );
    int                    o;
    int                    b;
    dhcp_client_pkg::mac_t mac;
    dhcp_msg_pkg::xid_t    xid;
    logic [31:0]           cookie;
    o      = i - dhcp_msg_pkg::hdr_len;
    b      = is_req ? 15 : 9;   // client id start
    mac    = dhcp_client_pkg::client_mac;
    xid    = dhcp_client_pkg::client_xid;
    cookie = dhcp_msg_pkg::magic_cookie;
    msg_byte = '0;
    if (i == dhcp_msg_pkg::off_op) msg_byte = dhcp_msg_pkg::op_boot_request;
    else if (i == dhcp_msg_pkg::off_op + 1) msg_byte = 8'd1;     // htype ethernet
    else if (i == dhcp_msg_pkg::off_op + 2) msg_byte = 8'd6;     // hlen
    else if (i >= dhcp_msg_pkg::off_xid && i < dhcp_msg_pkg::off_xid + 4)
      msg_byte = xid[8*(dhcp_msg_pkg::off_xid + 3 - i) +: 8];
    else if (i == dhcp_msg_pkg::off_flags) msg_byte = 8'h80;     // broadcast bit
    else if (i >= dhcp_msg_pkg::off_chaddr && i < dhcp_msg_pkg::off_chaddr + 6)
      msg_byte = mac[8*(dhcp_msg_pkg::off_chaddr + 5 - i) +: 8];
    else if (i >= dhcp_msg_pkg::off_cookie && i < dhcp_msg_pkg::hdr_len)
      msg_byte = cookie[8*(dhcp_msg_pkg::off_cookie + 3 - i) +: 8];
    else if (o == 0) msg_byte = dhcp_msg_pkg::opt_msg_type;
    else if (o == 1) msg_byte = 8'd1;
    else if (o == 2) msg_byte = is_req ? dhcp_msg_pkg::msg_request : dhcp_msg_pkg::msg_discover;
    else if (o == 3) msg_byte = dhcp_msg_pkg::opt_requested_ip;
    else if (o == 4) msg_byte = 8'd4;
    else if (o >= 5 && o <= 8) msg_byte = rip[8*(8 - o) +: 8];
    else if (is_req && o == 9) msg_byte = dhcp_msg_pkg::opt_server_id;
    else if (is_req && o == 10) msg_byte = 8'd4;
    else if (is_req && o >= 11 && o <= 14) msg_byte = sip[8*(14 - o) +: 8];
    else if (o == b) msg_byte = dhcp_msg_pkg::opt_client_id;
    else if (o == b + 1) msg_byte = 8'd7;
    else if (o == b + 2) msg_byte = 8'd1;                        // hw type before mac
    else if (o >= b + 3 && o <= b + 8) msg_byte = mac[8*(b + 8 - o) +: 8];
    else if (o == b + 9) msg_byte = dhcp_msg_pkg::opt_end;
    return msg_byte;
  endfunction

  // nothing more once the last byte is issued
  assign fire     = tx_rdy && tx_req && idx != tx_len;
  assign msg_sent = tx_eof;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_rdy <= 1'b0;
      tx_val <= 1'b0;
      tx_sof <= 1'b0;
      tx_eof <= 1'b0;
      idx    <= '0;
    end else begin
      tx_val <= fire;
      tx_sof <= fire && idx == '0;
      tx_eof <= fire && idx == tx_len - 16'd1;
      if (msg_start) begin
        tx_rdy <= 1'b1;
        idx    <= '0;
      end else begin
        if (fire) idx <= idx + 16'd1;
        if (tx_eof) tx_rdy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (msg_start) begin
      tx_len <= (msg_kind == dhcp_client_pkg::kind_request) ?
                dhcp_client_pkg::len_request : dhcp_client_pkg::len_discover;
    end
    if (fire) begin
      tx_dat <= msg_byte(int'(idx), msg_kind == dhcp_client_pkg::kind_request, req_ip, server_ip);
    end
  end

endmodule

// ==== dhcp_client.sv ====
`timescale 1ns/1ps

module dhcp_client (
  input  logic                     clk,
  input  logic                     fsm_rst,
  // from udp layer
  input  logic                     rx_sof,
  input  logic                     rx_val,
  input  dhcp_msg_pkg::byte_t      rx_dat,
  input  logic                     rx_eof,
  // to udp layer
  input  logic                     tx_req,
  output logic                     tx_rdy,
  output dhcp_client_pkg::tx_len_t tx_len,
  output logic                     tx_val,
  output logic                     tx_sof,
  output logic                     tx_eof,
  output dhcp_msg_pkg::byte_t      tx_dat,
  // status
  input  dhcp_msg_pkg::ipv4_t      preferred_ipv4,
  output logic                     ready,
  output logic                     error,
  output logic                     dhcp_success,
  output logic                     dhcp_timeout,
  output dhcp_msg_pkg::ipv4_t      assigned_ipv4,
  output dhcp_msg_pkg::ipv4_t      router_ipv4_addr,
  output logic                     router_ipv4_addr_val,
  output dhcp_msg_pkg::ipv4_t      subnet_mask,
  output logic                     subnet_mask_val
);

  logic                       reply_val, reply_router_pres, reply_mask_pres;
  dhcp_msg_pkg::byte_t        reply_op, reply_msg_type;
  dhcp_msg_pkg::xid_t         reply_xid;
  dhcp_msg_pkg::ipv4_t        reply_yiaddr, reply_siaddr, reply_router, reply_mask;
  logic                       msg_start, msg_sent;
  dhcp_client_pkg::msg_kind_t msg_kind;
  dhcp_msg_pkg::ipv4_t        req_ip, server_ip;

  dhcp_reply_parser u_parser (.*);  // rx bytes to reply fields

  dhcp_client_fsm u_fsm (.*);

  dhcp_msg_serializer u_serializer (.*);  // discover / request bytes out

endmodule

// ==== dhcp_client_tb.sv ====
`timescale 1ns/1ps

module dhcp_client_tb;

  localparam logic [1:0] rk_none  = 2'd0;
  localparam logic [1:0] rk_offer = 2'd1;
  localparam logic [1:0] rk_ack   = 2'd2;
  localparam logic [1:0] oc_retry = 2'd0;
  localparam logic [1:0] oc_lease = 2'd1;
  localparam logic [1:0] oc_fail  = 2'd2;

  localparam int attempt_cycles = dhcp_client_pkg::startup_ticks +
                                  dhcp_client_pkg::reply_timeout_ticks + 600;
  localparam int row_count = 5;
  localparam int wd_cycles = (dhcp_client_pkg::max_retries + 1) * attempt_cycles * row_count;

  localparam dhcp_msg_pkg::ipv4_t server_addr = 32'hc0a8_0101;
  localparam dhcp_msg_pkg::ipv4_t router_addr = 32'hc0a8_01fe;
  localparam dhcp_msg_pkg::ipv4_t mask_addr   = 32'hffff_ff00;

  typedef struct packed {
    logic [1:0] reply;
    logic       xid_good;
    logic       cookie_good;
    logic       with_router;
    logic       with_mask;
    logic [1:0] outcome;
  } row_t;

  localparam row_t scenarios [row_count] = '{
    '{rk_offer, 1'b0, 1'b1, 1'b0, 1'b0, oc_retry},  // foreign xid
    '{rk_offer, 1'b1, 1'b0, 1'b0, 1'b0, oc_retry},  // broken cookie
    '{rk_ack,   1'b1, 1'b1, 1'b1, 1'b1, oc_lease},
    '{rk_ack,   1'b1, 1'b1, 1'b0, 1'b0, oc_lease},  // bare ack
    '{rk_none,  1'b1, 1'b1, 1'b0, 1'b0, oc_fail}
  };

  logic clk, fsm_rst, rx_sof, rx_val, rx_eof, tx_req, tx_rdy, tx_val, tx_sof, tx_eof;
  dhcp_msg_pkg::byte_t      rx_dat, tx_dat;
  dhcp_client_pkg::tx_len_t tx_len;
  dhcp_msg_pkg::ipv4_t      preferred_ipv4, assigned_ipv4, router_ipv4_addr, subnet_mask;
  logic ready, error, dhcp_success, dhcp_timeout, router_ipv4_addr_val, subnet_mask_val;

  dhcp_msg_pkg::byte_t exp_q[$];
  dhcp_msg_pkg::byte_t rx_q[$];
  string               test_name;
  integer              seed;
  logic [31:0]         rnd;
  row_t                row;
  dhcp_msg_pkg::ipv4_t offer_ip;
  int                  r;
  int                  k;

  dhcp_client DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    stop_run("watchdog expired, the scenarios took longer than their cycle budget");
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
      stop_run($sformatf("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act));
  endtask

  function automatic dhcp_msg_pkg::byte_t byte_of(input logic [31:0] w, input int k);
    return w[8*(3-k) +: 8];  // network order
  endfunction

  function automatic dhcp_msg_pkg::byte_t mac_byte(input int k);
    dhcp_client_pkg::mac_t mac;
    mac = dhcp_client_pkg::client_mac;
    return mac[8*(5-k) +: 8];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // expected client message and server replies
  //////////////////////////////////////////////////////////////////////

  task automatic build_header(inout dhcp_msg_pkg::byte_t q[$], input dhcp_msg_pkg::byte_t op,
                              input logic [31:0] xid, input logic [31:0] cookie);
    q.delete();
    for (int i = 0; i < dhcp_msg_pkg::hdr_len; i++) q.push_back(8'h00);
    q[dhcp_msg_pkg::off_op]     = op;
    q[dhcp_msg_pkg::off_op + 1] = 8'h01;
    q[dhcp_msg_pkg::off_op + 2] = 8'h06;
    for (int i = 0; i < 4; i++) begin
      q[dhcp_msg_pkg::off_xid + i]    = byte_of(xid, i);
      q[dhcp_msg_pkg::off_cookie + i] = byte_of(cookie, i);
    end
    for (int i = 0; i < 6; i++) q[dhcp_msg_pkg::off_chaddr + i] = mac_byte(i);
  endtask

  task automatic build_expected(input logic is_req, input dhcp_msg_pkg::ipv4_t rip,
                                input dhcp_msg_pkg::ipv4_t sip);
    build_header(exp_q, dhcp_msg_pkg::op_boot_request, dhcp_client_pkg::client_xid,
                 dhcp_msg_pkg::magic_cookie);
    exp_q[dhcp_msg_pkg::off_flags] = 8'h80;
    exp_q.push_back(8'd53);
    exp_q.push_back(8'd1);
    exp_q.push_back(is_req ? 8'd3 : 8'd1);
    exp_q.push_back(8'd50);
    exp_q.push_back(8'd4);
    for (int i = 0; i < 4; i++) exp_q.push_back(byte_of(rip, i));
    if (is_req) begin
      exp_q.push_back(8'd54);
      exp_q.push_back(8'd4);
      for (int i = 0; i < 4; i++) exp_q.push_back(byte_of(sip, i));
    end
    exp_q.push_back(8'd61);
    exp_q.push_back(8'd7);
    exp_q.push_back(8'd1);
    for (int i = 0; i < 6; i++) exp_q.push_back(mac_byte(i));
    exp_q.push_back(8'd255);
  endtask

  task automatic build_reply(input dhcp_msg_pkg::byte_t mtype, input logic [31:0] xid,
                             input logic [31:0] cookie, input dhcp_msg_pkg::ipv4_t yi,
                             input logic rtr, input logic msk);
    build_header(rx_q, dhcp_msg_pkg::op_boot_reply, xid, cookie);
    for (int i = 0; i < 4; i++) begin
      rx_q[dhcp_msg_pkg::off_yiaddr + i] = byte_of(yi, i);
      rx_q[dhcp_msg_pkg::off_siaddr + i] = byte_of(server_addr, i);
    end
    rx_q.push_back(8'd0);  // pad
    rx_q.push_back(8'd53);
    rx_q.push_back(8'd1);
    rx_q.push_back(mtype);
    rx_q.push_back(8'd51);  // lease time is not decoded
    rx_q.push_back(8'd4);
    for (int i = 0; i < 4; i++) rx_q.push_back(byte_of(32'd3600, i));
    if (rtr) begin
      rx_q.push_back(8'd3);
      rx_q.push_back(8'd4);
      for (int i = 0; i < 4; i++) rx_q.push_back(byte_of(router_addr, i));
    end
    if (msk) begin
      rx_q.push_back(8'd1);
      rx_q.push_back(8'd4);
      for (int i = 0; i < 4; i++) rx_q.push_back(byte_of(mask_addr, i));
    end
    rx_q.push_back(8'd255);
  endtask

  //////////////////////////////////////////////////////////////////////
  // udp side drivers
  //////////////////////////////////////////////////////////////////////

  task automatic send_reply();
    for (int i = 0; i < rx_q.size(); i++) begin
      rx_val = 1'b1;
      rx_sof = (i == 0);
      rx_eof = (i == rx_q.size() - 1);
      rx_dat = rx_q[i];
      @(negedge clk);
    end
    rx_val = 1'b0;
    rx_sof = 1'b0;
    rx_eof = 1'b0;
  endtask

  task automatic collect_msg(input string what, input logic is_req,
                             input dhcp_msg_pkg::ipv4_t rip, input dhcp_msg_pkg::ipv4_t sip);
    int n;
    int waited;
    build_expected(is_req, rip, sip);
    waited = 0;
    while (!tx_rdy) begin
      if (waited == attempt_cycles) stop_run({"no message came out in time, waiting for ", what});
      @(negedge clk);
      waited++;
    end
    check({what, " tx_len"}, 32'(exp_q.size()), 32'(tx_len));
    n = 0;
    waited = 0;
    while (n < exp_q.size()) begin
      rnd = $random(seed);
      tx_req = rnd[0];
      @(negedge clk);
      if (tx_val) begin
        check($sformatf("%s byte %0d", what, n), 32'(exp_q[n]), 32'(tx_dat));
        check($sformatf("%s sof %0d", what, n), 32'(n == 0), 32'(tx_sof));
        check($sformatf("%s eof %0d", what, n), 32'(n == exp_q.size() - 1), 32'(tx_eof));
        n++;
      end
      waited++;
      if (waited > 8 * exp_q.size()) stop_run({"transmit stream stalled during ", what});
    end
    tx_req = 1'b0;
    @(negedge clk);
    check({what, " tx_rdy after eof"}, 32'd0, 32'(tx_rdy));
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    while (!(ready || error)) begin
      if (waited == attempt_cycles) stop_run("client never reported ready or error");
      @(negedge clk);
      waited++;
    end
  endtask

  initial begin
    seed           = 32'hdfb4_c827;
    fsm_rst        = 1'b1;
    rx_sof         = 1'b0;
    rx_val         = 1'b0;
    rx_eof         = 1'b0;
    rx_dat         = '0;
    tx_req         = 1'b0;
    preferred_ipv4 = '0;
    for (r = 0; r < row_count; r++) begin
      row            = scenarios[r];
      test_name      = $sformatf("scenario %0d", r);
      preferred_ipv4 = 32'hc0a8_0164 + 32'(r);
      offer_ip       = 32'hc0a8_0132 + 32'(r);
      fsm_rst        = 1'b1;
      repeat (16) @(negedge clk);
      fsm_rst = 1'b0;
      check("tx_rdy after reset", 32'd0, 32'(tx_rdy));
      check("ready after reset", 32'd0, 32'(ready));
      collect_msg("discover", 1'b0, preferred_ipv4, '0);
      if (row.reply == rk_none) begin
        for (k = 1; k < dhcp_client_pkg::max_retries; k++)
          collect_msg("discover retry", 1'b0, preferred_ipv4, '0);
      end else begin
        build_reply(dhcp_msg_pkg::msg_offer,
                    row.xid_good ? dhcp_client_pkg::client_xid : dhcp_client_pkg::client_xid ^ 1,
                    row.cookie_good ? dhcp_msg_pkg::magic_cookie : dhcp_msg_pkg::magic_cookie ^ 1,
                    offer_ip, 1'b0, 1'b0);
        send_reply();
        if (row.outcome == oc_retry) begin
          collect_msg("discover after rejected offer", 1'b0, preferred_ipv4, '0);
          check("ready after rejected offer", 32'd0, 32'(ready));
        end else begin
          collect_msg("request", 1'b1, offer_ip, server_addr);
          build_reply(dhcp_msg_pkg::msg_ack, dhcp_client_pkg::client_xid,
                      dhcp_msg_pkg::magic_cookie, offer_ip, row.with_router, row.with_mask);
          send_reply();
        end
      end
      if (row.outcome == oc_lease) begin
        wait_done();
        check("ready", 32'd1, 32'(ready));
        check("dhcp_success", 32'd1, 32'(dhcp_success));
        check("error", 32'd0, 32'(error));
        check("assigned_ipv4", offer_ip, assigned_ipv4);
        check("router valid", 32'(row.with_router), 32'(router_ipv4_addr_val));
        check("mask valid", 32'(row.with_mask), 32'(subnet_mask_val));
        if (row.with_router) check("router", router_addr, router_ipv4_addr);
        if (row.with_mask) check("subnet mask", mask_addr, subnet_mask);
      end else if (row.outcome == oc_fail) begin
        wait_done();
        check("error", 32'd1, 32'(error));
        check("dhcp_timeout", 32'd1, 32'(dhcp_timeout));
        check("ready", 32'd0, 32'(ready));
        // client must stay silent once it gave up
        repeat (dhcp_client_pkg::startup_ticks + dhcp_client_pkg::reply_timeout_ticks) begin
          @(negedge clk);
          check("tx_rdy after failure", 32'd0, 32'(tx_rdy));
        end
      end
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== dhcp_client.f ====
dhcp_msg_pkg.sv
dhcp_client_pkg.sv
dhcp_reply_parser.sv
dhcp_client_fsm.sv
dhcp_msg_serializer.sv
dhcp_client.sv
dhcp_client_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the dhcp client testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f dhcp_client.f --top-module dhcp_client_tb -o dhcp_client_sim

./obj_dir/dhcp_client_sim
